/* Bender.yml */
package:
  name: gpio_apb

sources:
  - gpio_pkg.sv
  - gpio_cfg_if.sv
  - gpio_apb_regs.sv
  - gpio_in_sync.sv
  - gpio_irq.sv
  - gpio_top.sv
  - target: simulation
    files:
      - tb_clk_gen.sv
      - tb_gpio_top.sv

/* gpio_apb_regs.sv */
// ==========================================================
// GPIO APB decode, configuration registers, read mux
// and interrupt status clear strobe
// ==========================================================
`timescale 1ns/1ns

module gpio_apb_regs (
    input  logic                HCLK,
    input  logic                HRESETn,
    input  gpio_pkg::apb_addr_t paddr,
    input  gpio_pkg::apb_data_t pwdata,
    input  logic                pwrite,
    input  logic                psel,
    input  logic                penable,
    output gpio_pkg::apb_data_t prdata,
    input  gpio_pkg::pad_vec_t  pad_in,
    input  gpio_pkg::pad_vec_t  status,
    output gpio_pkg::pad_vec_t  gpio_out,
    output logic                status_clr,
    gpio_cfg_if.regs            cfg
);
    import gpio_pkg::*;

    reg_idx_t     idx;
    logic         wr_en;
    logic         rd_en;

    pad_vec_t     dir_q;
    pad_vec_t     en_q;
    pad_vec_t     out_q;
    pad_vec_t     inten_q;
    inttype_vec_t inttype_q;

    assign idx   = paddr[5:2];
    assign wr_en = psel & penable & pwrite;
    assign rd_en = psel & penable & ~pwrite;

    // Status bits clear on the edge that ends the read
    assign status_clr = rd_en && (idx == REG_INTSTATUS);

    always_ff @(posedge HCLK or negedge HRESETn)
    begin
        if (!HRESETn)
        begin
            dir_q     <= '0;
            en_q      <= '0;
            out_q     <= '0;
            inten_q   <= '0;
            inttype_q <= '0;
        end
        else if (wr_en)
        begin
            case (idx)
                REG_PADDIR:
                begin
                    dir_q   <= pwdata;
                    inten_q <= inten_q & ~pwdata;  // Outputs lose their interrupt
                end
                REG_GPIOEN:
                    en_q <= pwdata;
                REG_PADOUT:
                    out_q <= pwdata;
                REG_PADOUTSET:
                    out_q <= out_q | pwdata;
                REG_PADOUTCLR:
                    out_q <= out_q & ~pwdata;
                REG_INTEN:
                    inten_q <= (pwdata & ~dir_q) | (inten_q & dir_q);
                REG_INTTYPE_LO:
                    inttype_q[PAD_NUM/2-1:0] <= pwdata;
                REG_INTTYPE_HI:
                    inttype_q[PAD_NUM-1:PAD_NUM/2] <= pwdata;
                default:
                    ;  // PADIN, INTSTATUS and holes
            endcase
        end
    end

    always_comb
    begin
        prdata = '0;
        if (rd_en)
        begin
            case (idx)
                REG_PADDIR:     prdata = dir_q;
                REG_GPIOEN:     prdata = en_q;
                REG_PADIN:      prdata = pad_in;
                REG_PADOUT:     prdata = out_q;
                REG_INTEN:      prdata = inten_q;
                REG_INTTYPE_LO: prdata = inttype_q[PAD_NUM/2-1:0];
                REG_INTTYPE_HI: prdata = inttype_q[PAD_NUM-1:PAD_NUM/2];
                REG_INTSTATUS:  prdata = status;
                default:        prdata = '0;
            endcase
        end
    end

    assign gpio_out    = out_q;
    assign cfg.dir     = dir_q;
    assign cfg.en      = en_q;
    assign cfg.inten   = inten_q;
    assign cfg.inttype = inttype_q;

    // Clear strobe only after a matching read setup, and never two cycles running
    a_status_clr_pulse: assert property (
        @(posedge HCLK) disable iff (!HRESETn)
        status_clr |-> $past(psel && !penable && !pwrite && idx == REG_INTSTATUS)
            ##1 !status_clr
    );

endmodule

/* gpio_cfg_if.sv */
// ==========================================================
// Pad configuration bundle between register block and
// interrupt logic
// ==========================================================
`timescale 1ns/1ns

interface gpio_cfg_if;
    import gpio_pkg::*;

    pad_vec_t     dir;      // 1 = output
    pad_vec_t     en;
    pad_vec_t     inten;
    inttype_vec_t inttype;

    modport regs (
        output dir,
        output en,
        output inten,
        output inttype
    );

    modport irq (
        input dir,
        input en,
        input inten,
        input inttype
    );

endinterface

/* gpio_in_sync.sv */
// ==========================================================
// Per-pad three-stage input synchronizer, gated by the
// pad enable bit
// ==========================================================
`timescale 1ns/1ns

module gpio_in_sync (
    input  logic               HCLK,
    input  logic               HRESETn,
    input  gpio_pkg::pad_vec_t gpio_in,
    input  gpio_pkg::pad_vec_t en,
    output gpio_pkg::pad_vec_t sync_stage,
    output gpio_pkg::pad_vec_t pad_in
);
    import gpio_pkg::*;

    pad_vec_t sync0_q;
    pad_vec_t sync1_q;
    pad_vec_t prev_q;

    always_ff @(posedge HCLK or negedge HRESETn)
    begin
        if (!HRESETn)
        begin
            sync0_q <= '0;
            sync1_q <= '0;
            prev_q  <= '0;
        end
        else
        begin
            for (int i = 0; i < PAD_NUM; i++)
            begin
                if (en[i])  // Disabled pad freezes its chain
                begin
                    sync0_q[i] <= gpio_in[i];
                    sync1_q[i] <= sync0_q[i];
                    prev_q[i]  <= sync1_q[i];
                end
            end
        end
    end

    assign sync_stage = sync1_q;
    assign pad_in     = prev_q;  // Also the edge reference

endmodule

/* gpio_irq.sv */
// ==========================================================
// GPIO edge detection, type filter, sticky status and
// two-flop interrupt outputs
// ==========================================================
`timescale 1ns/1ns

module gpio_irq (
    input  logic               HCLK,
    input  logic               HRESETn,
    input  gpio_pkg::pad_vec_t sync_stage,
    input  gpio_pkg::pad_vec_t pad_in,
    input  logic               status_clr,
    output gpio_pkg::pad_vec_t status,
    output gpio_pkg::pad_vec_t interrupt,
    gpio_cfg_if.irq            cfg
);
    import gpio_pkg::*;

    pad_vec_t rise;
    pad_vec_t fall;
    pad_vec_t type_hit;
    pad_vec_t qual;

    pad_vec_t status_q;
    pad_vec_t irq_q1;
    pad_vec_t irq_q2;

    assign rise =  sync_stage & ~pad_in;
    assign fall = ~sync_stage &  pad_in;

    always_comb
    begin
        for (int i = 0; i < PAD_NUM; i++)
        begin
            case (cfg.inttype[i])
                INT_FALL: type_hit[i] = fall[i];
                INT_RISE: type_hit[i] = rise[i];
                INT_BOTH: type_hit[i] = rise[i] | fall[i];
                default:  type_hit[i] = 1'b0;  // 11 is silent
            endcase
        end
    end

    assign qual = type_hit & cfg.en & ~cfg.dir & cfg.inten;

    always_ff @(posedge HCLK or negedge HRESETn)
    begin
        if (!HRESETn)
        begin
            status_q <= '0;
        end
        else
        begin
            // A fresh event wins over the clear
            status_q <= (status_clr ? '0 : status_q) | qual;
        end
    end

    always_ff @(posedge HCLK or negedge HRESETn)
    begin
        if (!HRESETn)
        begin
            irq_q1 <= '0;
            irq_q2 <= '0;
        end
        else
        begin
            irq_q1 <= qual;
            irq_q2 <= irq_q1;
        end
    end

    assign status    = status_q;
    assign interrupt = irq_q2;

    // An interrupt always follows a change of the sampled pad level
    a_irq_on_pad_change: assert property (
        @(posedge HCLK) disable iff (!HRESETn)
        (interrupt & ~($past(pad_in) ^ $past(pad_in, 2))) == '0
    );

endmodule

/* gpio_pkg.sv */
// ==========================================================
// GPIO shared widths, pad vector types, register word
// offsets and interrupt type encoding
// ==========================================================

package gpio_pkg;

    localparam int PAD_NUM        = 32;
    localparam int APB_ADDR_WIDTH = 12;
    localparam int APB_DATA_WIDTH = 32;

    typedef logic [PAD_NUM-1:0]        pad_vec_t;
    typedef logic [APB_DATA_WIDTH-1:0] apb_data_t;
    typedef logic [APB_ADDR_WIDTH-1:0] apb_addr_t;

    // Two bits per pad, 11 leaves the pad silent
    typedef logic [1:0] inttype_t;
    typedef inttype_t [PAD_NUM-1:0] inttype_vec_t;

    localparam inttype_t INT_FALL = 2'b00;
    localparam inttype_t INT_RISE = 2'b01;
    localparam inttype_t INT_BOTH = 2'b10;

    // Word index from PADDR[5:2]
    typedef logic [3:0] reg_idx_t;

    localparam reg_idx_t REG_PADDIR     = 4'd0;  // 0x00
    localparam reg_idx_t REG_GPIOEN     = 4'd1;  // 0x04
    localparam reg_idx_t REG_PADIN      = 4'd2;  // 0x08
    localparam reg_idx_t REG_PADOUT     = 4'd3;  // 0x0C
    localparam reg_idx_t REG_PADOUTSET  = 4'd4;  // 0x10
    localparam reg_idx_t REG_PADOUTCLR  = 4'd5;  // 0x14
    localparam reg_idx_t REG_INTEN      = 4'd6;  // 0x18
    localparam reg_idx_t REG_INTTYPE_LO = 4'd7;  // 0x1C, pads 0..15
    localparam reg_idx_t REG_INTTYPE_HI = 4'd8;  // 0x20, pads 16..31
    localparam reg_idx_t REG_INTSTATUS  = 4'd9;  // 0x24

endpackage

/* gpio_top.sv */
// ==========================================================
// GPIO top level, APB slave and pad ports around the
// register block, synchronizer and interrupt logic
// ==========================================================
`timescale 1ns/1ns

module gpio_top (
    input  logic                HCLK,
    input  logic                HRESETn,
    input  gpio_pkg::apb_addr_t PADDR,
    input  gpio_pkg::apb_data_t PWDATA,
    input  logic                PWRITE,
    input  logic                PSEL,
    input  logic                PENABLE,
    output gpio_pkg::apb_data_t PRDATA,
    output logic                PREADY,
    output logic                PSLVERR,
    input  gpio_pkg::pad_vec_t  gpio_in,
    output gpio_pkg::pad_vec_t  gpio_in_sync,
    output gpio_pkg::pad_vec_t  gpio_out,
    output gpio_pkg::pad_vec_t  gpio_dir,
    output gpio_pkg::pad_vec_t  interrupt_o
);
    import gpio_pkg::*;

    pad_vec_t pad_in;
    pad_vec_t status;
    logic     status_clr;

    gpio_cfg_if cfg_if ();

    gpio_apb_regs i_gpio_apb_regs (
        .HCLK       (HCLK),
        .HRESETn    (HRESETn),
        .paddr      (PADDR),
        .pwdata     (PWDATA),
        .pwrite     (PWRITE),
        .psel       (PSEL),
        .penable    (PENABLE),
        .prdata     (PRDATA),
        .pad_in     (pad_in),
        .status     (status),
        .gpio_out   (gpio_out),
        .status_clr (status_clr),
        .cfg        (cfg_if.regs)
    );

    gpio_in_sync i_gpio_in_sync (
        .HCLK       (HCLK),
        .HRESETn    (HRESETn),
        .gpio_in    (gpio_in),
        .en         (cfg_if.en),
        .sync_stage (gpio_in_sync),
        .pad_in     (pad_in)
    );

    gpio_irq i_gpio_irq (
        .HCLK       (HCLK),
        .HRESETn    (HRESETn),
        .sync_stage (gpio_in_sync),
        .pad_in     (pad_in),
        .status_clr (status_clr),
        .status     (status),
        .interrupt  (interrupt_o),
        .cfg        (cfg_if.irq)
    );

    assign gpio_dir = cfg_if.dir;
    assign PREADY   = 1'b1;  // Zero wait states
    assign PSLVERR  = 1'b0;

endmodule

/* tb_clk_gen.sv */
// ==========================================================
// Testbench clock and reset generator
// ==========================================================
`timescale 1ns/1ns

module tb_clk_gen (
    output logic HCLK,
    output logic HRESETn
);
    localparam int HALF_PERIOD = 10;  // 20 ns clock
    localparam int RST_CYCLES  = 8;

    initial
    begin
        HCLK    = 1'b0;
        HRESETn = 1'b0;
        repeat (RST_CYCLES) @(posedge HCLK);
        @(negedge HCLK);
        HRESETn = 1'b1;
    end

    always #(HALF_PERIOD) HCLK = ~HCLK;

endmodule

/* tb_gpio_top.sv */
// ==========================================================
// GPIO testbench, stimulus table with APB register, pad
// input and interrupt checks
// ==========================================================
`timescale 1ns/1ns

module tb_gpio_top;
    import gpio_pkg::*;

    localparam int SAMPLE_DLY   = 5;  // Middle of the low phase
    localparam int SYNC_TIMEOUT = 5;
    localparam int IRQ_TIMEOUT  = 10;
    localparam int RST_TIMEOUT  = 20;

    typedef enum logic [2:0] {OP_WRITE, OP_READ, OP_PADS, OP_IRQ, OP_PINS} op_t;

    typedef struct packed {
        op_t       op;
        reg_idx_t  idx;
        apb_data_t data;  // Expected gpio_dir for OP_PINS
        pad_vec_t  pads;
        apb_data_t exp;
    } step_t;

    logic      HCLK, HRESETn, PWRITE, PSEL, PENABLE, PREADY, PSLVERR;
    apb_addr_t PADDR;
    apb_data_t PWDATA, PRDATA;
    pad_vec_t  gpio_in, gpio_in_sync, gpio_out, gpio_dir, interrupt_o;

    step_t     steps [128];
    int        n_steps;
    int        n_tests;
    int        n_fail;
    apb_data_t rnd [8];

    tb_clk_gen i_clk_gen (.*);
    gpio_top   i_gpio_top (.*);

    function automatic void add_step(op_t op, reg_idx_t idx, apb_data_t data,
                                     pad_vec_t pads, apb_data_t exp);
        steps[n_steps] = {op, idx, data, pads, exp};
        n_steps++;
    endfunction

    task automatic check_data(input string name, input apb_data_t got, input apb_data_t exp);
        n_tests++;
        if (got === exp)
            $display("ok       %s = %08h", name, got);
        else
        begin
            n_fail++;
            $display("mismatch %s: got %08h, expected %08h", name, got, exp);
        end
    endtask

    task automatic check_pads(input string name, input pad_vec_t got, input pad_vec_t exp);
        n_tests++;
        if (got === exp)
            $display("ok       %s = %08h", name, got);
        else
        begin
            n_fail++;
            $display("mismatch %s: got %08h, expected %08h", name, got, exp);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        n_tests++;
        if (got === exp)
            $display("ok       %s = %0h", name, got);
        else
        begin
            n_fail++;
            $display("mismatch %s: got %0h, expected %0h", name, got, exp);
        end
    endtask

    task automatic apb_write(input reg_idx_t idx, input apb_data_t data);
        @(negedge HCLK);
        PADDR   = {6'd0, idx, 2'b00};
        PWDATA  = data;
        PWRITE  = 1'b1;
        PSEL    = 1'b1;
        @(negedge HCLK);
        PENABLE = 1'b1;
        @(negedge HCLK);
        PSEL    = 1'b0;
        PENABLE = 1'b0;
        PWRITE  = 1'b0;
    endtask

    task automatic apb_read(input reg_idx_t idx, output apb_data_t data);
        @(negedge HCLK);
        PADDR   = {6'd0, idx, 2'b00};
        PWRITE  = 1'b0;
        PSEL    = 1'b1;
        @(negedge HCLK);
        PENABLE = 1'b1;
        #(SAMPLE_DLY);
        data    = PRDATA;
        @(negedge HCLK);
        PSEL    = 1'b0;
        PENABLE = 1'b0;
    endtask

    task automatic run_step(input step_t s);
        apb_data_t rdata;
        pad_vec_t  seen;
        bit        found;
        case (s.op)
            OP_WRITE:
                apb_write(s.idx, s.data);
            OP_READ:
            begin
                apb_read(s.idx, rdata);
                check_data($sformatf("PRDATA reg %0d", s.idx), rdata, s.exp);
            end
            OP_PINS:
            begin
                check_pads("gpio_out", gpio_out, s.exp);
                check_pads("gpio_dir", gpio_dir, s.data);
                check_flag("PREADY", PREADY, 1'b1);
                check_flag("PSLVERR", PSLVERR, 1'b0);
            end
            OP_PADS:
            begin
                @(negedge HCLK);
                gpio_in = s.pads;
                for (int c = 0; c < SYNC_TIMEOUT; c++)
                begin
                    @(negedge HCLK);
                    if (gpio_in_sync === s.exp)
                        break;
                end
                check_pads("gpio_in_sync", gpio_in_sync, s.exp);
            end
            default:
            begin
                @(negedge HCLK);
                gpio_in = s.pads;
                found   = 1'b0;
                seen    = '0;
                for (int c = 0; c < IRQ_TIMEOUT; c++)
                begin
                    @(negedge HCLK);
                    if (!found && interrupt_o !== '0)
                    begin
                        found = 1'b1;
                        seen  = interrupt_o;
                    end
                    if (found && s.exp !== '0)
                        break;
                end
                if (s.exp === '0)
                    check_pads("interrupt_o", seen, '0);
                else if (!found)
                begin
                    n_tests++;
                    n_fail++;
                    $display("timeout: no pulse on interrupt_o within %0d cycles, pads %08h",
                             IRQ_TIMEOUT, s.exp);
                end
                else
                begin
                    check_pads("interrupt_o", seen, s.exp);
                    @(negedge HCLK);
                    check_pads("interrupt_o after pulse", interrupt_o, '0);  // One cycle only
                end
            end
        endcase
    endtask

    task automatic build_table();
        apb_data_t out_exp;
        apb_data_t inten_exp;
        apb_data_t mix;
        for (int i = 0; i <= REG_INTSTATUS; i++)  // Reset values
            add_step(OP_READ, reg_idx_t'(i), '0, '0, '0);
        add_step(OP_PINS,  4'd0, '0, '0, '0);
        add_step(OP_IRQ,   4'd0, '0, '0, '0);
        add_step(OP_WRITE, REG_PADDIR, rnd[0], '0, '0);
        add_step(OP_READ,  REG_PADDIR, '0, '0, rnd[0]);
        add_step(OP_WRITE, REG_GPIOEN, rnd[1], '0, '0);
        add_step(OP_READ,  REG_GPIOEN, '0, '0, rnd[1]);
        add_step(OP_WRITE, REG_PADOUT, rnd[2], '0, '0);
        add_step(OP_READ,  REG_PADOUT, '0, '0, rnd[2]);
        add_step(OP_PINS,  4'd0, rnd[0], '0, rnd[2]);
        add_step(OP_WRITE, REG_INTTYPE_LO, rnd[3], '0, '0);
        add_step(OP_READ,  REG_INTTYPE_LO, '0, '0, rnd[3]);
        add_step(OP_WRITE, REG_INTTYPE_HI, rnd[4], '0, '0);
        add_step(OP_READ,  REG_INTTYPE_HI, '0, '0, rnd[4]);
        add_step(OP_WRITE, 4'd11, rnd[5], '0, '0);  // Hole in the map
        add_step(OP_READ,  4'd11, '0, '0, '0);
        add_step(OP_WRITE, REG_PADIN, rnd[5], '0, '0);
        add_step(OP_READ,  REG_PADIN, '0, '0, '0);
        out_exp = rnd[2] | rnd[5];
        add_step(OP_WRITE, REG_PADOUTSET, rnd[5], '0, '0);
        add_step(OP_READ,  REG_PADOUT, '0, '0, out_exp);
        out_exp = out_exp & ~rnd[6];
        add_step(OP_WRITE, REG_PADOUTCLR, rnd[6], '0, '0);
        add_step(OP_PINS,  4'd0, rnd[0], '0, out_exp);
        inten_exp = rnd[7] & ~rnd[0];
        add_step(OP_WRITE, REG_INTEN, rnd[7], '0, '0);
        add_step(OP_READ,  REG_INTEN, '0, '0, inten_exp);
        add_step(OP_WRITE, REG_PADDIR, rnd[1], '0, '0);
        add_step(OP_READ,  REG_INTEN, '0, '0, inten_exp & ~rnd[1]);
        // Upper half of the synchronizer frozen on the second word
        add_step(OP_WRITE, REG_PADDIR, '0, '0, '0);
        add_step(OP_WRITE, REG_INTEN, '0, '0, '0);
        add_step(OP_WRITE, REG_GPIOEN, 32'hFFFF_FFFF, '0, '0);
        add_step(OP_PADS,  4'd0, '0, rnd[3], rnd[3]);
        add_step(OP_READ,  REG_PADIN, '0, '0, rnd[3]);
        mix = (rnd[4] & 32'h0000_FFFF) | (rnd[3] & 32'hFFFF_0000);
        add_step(OP_WRITE, REG_GPIOEN, 32'h0000_FFFF, '0, '0);
        add_step(OP_PADS,  4'd0, '0, rnd[4], mix);
        add_step(OP_READ,  REG_PADIN, '0, '0, mix);
        // Pad 0 fall, 1 rise, 2 both, 3 none, 4 disabled, 5 output, 6 masked
        add_step(OP_WRITE, REG_PADDIR, 32'h0000_0020, '0, '0);
        add_step(OP_WRITE, REG_GPIOEN, 32'hFFFF_FFFF, '0, '0);
        add_step(OP_PADS,  4'd0, '0, '0, '0);
        add_step(OP_WRITE, REG_INTTYPE_LO, 32'hFFFF_EAE4, '0, '0);
        add_step(OP_WRITE, REG_INTTYPE_HI, 32'hFFFF_FFFF, '0, '0);
        add_step(OP_WRITE, REG_GPIOEN, 32'hFFFF_FFEF, '0, '0);
        add_step(OP_WRITE, REG_INTEN, 32'hFFFF_FFBF, '0, '0);
        add_step(OP_READ,  REG_INTEN, '0, '0, 32'hFFFF_FF9F);
        add_step(OP_READ,  REG_INTSTATUS, '0, '0, '0);
        add_step(OP_IRQ,   4'd0, '0, 32'h03, 32'h02);
        add_step(OP_IRQ,   4'd0, '0, 32'h00, 32'h01);
        add_step(OP_IRQ,   4'd0, '0, 32'h04, 32'h04);
        add_step(OP_IRQ,   4'd0, '0, 32'h00, 32'h04);
        add_step(OP_IRQ,   4'd0, '0, 32'h78, 32'h00);
        add_step(OP_IRQ,   4'd0, '0, 32'h00, 32'h00);
        add_step(OP_READ,  REG_INTSTATUS, '0, '0, 32'h07);
        add_step(OP_READ,  REG_INTSTATUS, '0, '0, '0);
    endtask

    initial
    begin
        PADDR   = '0;
        PWDATA  = '0;
        PWRITE  = 1'b0;
        PSEL    = 1'b0;
        PENABLE = 1'b0;
        gpio_in = '0;
        n_steps = 0;
        n_tests = 0;
        n_fail  = 0;
        void'($urandom(32'h5c14));
        foreach (rnd[i])
            rnd[i] = $urandom();
        build_table();
        for (int c = 0; c < RST_TIMEOUT && !HRESETn; c++)
            @(negedge HCLK);
        if (!HRESETn)
        begin
            n_fail++;
            $display("HRESETn was still low after %0d cycles", RST_TIMEOUT);
        end
        else
        begin
            for (int i = 0; i < n_steps; i++)
                run_step(steps[i]);
        end
        $display("%0d checks run, %0d failed", n_tests, n_fail);
        if (n_fail == 0)
            $display("All tests passed!");
        else
            $display("Test failures found");
        $finish;
    end

endmodule

/* vlog.f */
gpio_pkg.sv
gpio_cfg_if.sv
gpio_apb_regs.sv
gpio_in_sync.sv
gpio_irq.sv
gpio_top.sv
tb_clk_gen.sv
tb_gpio_top.sv
